/* Makefile */
TOP = exec_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f exec_unit.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* exec_alu.sv */
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input issue_t issue,
	output logic alu_valid,
	output alu_result_t alu
);

	word_t op_a;
	word_t op_b;
	word_t result;

	assign op_a = issue.req.op_a;
	assign op_b = issue.req.op_b;

	always_comb begin
		case (issue.req.op)
			op_add: begin
				result = op_a + op_b;
			end
			op_sub: begin
				result = op_a - op_b;
			end
			op_and: begin
				result = op_a & op_b;
			end
			op_or: begin
				result = op_a | op_b;
			end
			op_clr: begin
				result = op_a & ~op_b; // Bits set in op_b are cleared
			end
			op_eq: begin
				result = {{(word_width-1){1'b0}}, op_a == op_b};
			end
			op_lt: begin
				result = {{(word_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			op_ltu: begin
				result = {{(word_width-1){1'b0}}, op_a < op_b};
			end
			op_xor: begin
				result = op_a ^ op_b;
			end
			op_nop: begin
				result = op_a;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_valid <= 1'b0;
		end else begin
			alu_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			alu.issue <= issue;
			alu.result <= issue.illegal ? '0 : result; // Illegal ops produce no value
		end
	end

endmodule

/* exec_arith_checker.sv */
`timescale 1ns/1ps

module exec_arith_checker import exec_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input issue_t issue,
	input logic rd_wen,
	input reg_addr_t rd_waddr,
	input word_t rd_wdata,
	input logic instr_complete,
	output check_status_t status
);

	issue_t stage1;
	issue_t stage2;
	logic stage1_valid;
	logic stage2_valid;
	logic [1:0] wr_count;
	logic [1:0] writes_now;
	reg_addr_t last_waddr;
	word_t last_wdata;
	reg_addr_t seen_waddr;
	word_t seen_wdata;
	word_t a;
	word_t b;
	word_t expected;

	// Two stages line the issued instruction up with instr_complete
	always_ff @(posedge clock) begin
		stage1 <= issue;
		stage2 <= stage1;
	end

	// Writes in the completion cycle count too
	always_comb begin
		if (rd_wen && wr_count != 2'd3) begin
			writes_now = wr_count + 2'd1;
		end else begin
			writes_now = wr_count;
		end
		seen_waddr = rd_wen ? rd_waddr : last_waddr;
		seen_wdata = rd_wen ? rd_wdata : last_wdata;
	end

	assign a = stage2.req.op_a;
	assign b = stage2.req.op_b;

	// Independent recomputation of every operation
	always_comb begin
		case (stage2.req.op)
			op_add: expected = a + b;
			op_sub: expected = a + ~b + 32'd1;
			op_and: expected = ~(~a | ~b);
			op_or: expected = ~(~a & ~b);
			op_clr: expected = a ^ (a & b);
			op_eq: expected = {31'd0, ~|(a ^ b)};
			op_lt: expected = {31'd0, (a ^ sign_mask) < (b ^ sign_mask)};
			op_ltu: expected = {31'd0, a < b};
			op_xor: expected = (a | b) & ~(a & b);
			op_nop: expected = a;
			default: expected = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rd_wen) begin
			last_waddr <= rd_waddr;
			last_wdata <= rd_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			stage1_valid <= 1'b0;
			stage2_valid <= 1'b0;
			wr_count <= '0;
			status <= '0;
		end else begin
			stage1_valid <= issue_valid;
			stage2_valid <= stage1_valid;
			if (instr_complete) begin
				wr_count <= '0;
				if (!stage2_valid) begin
					status.write_count_error <= 1'b1; // Completion with nothing in flight
				end else if (stage2.illegal) begin
					status.illegal_op <= 1'b1;
					if (writes_now != 2'd0)
						status.write_count_error <= 1'b1;
				end else begin
					if (writes_now != 2'd1)
						status.write_count_error <= 1'b1;
					if (writes_now != 2'd0 && seen_waddr != stage2.req.rd)
						status.rd_mismatch <= 1'b1;
					if (writes_now != 2'd0 && seen_wdata != expected)
						status.data_mismatch <= 1'b1;
				end
			end else begin
				wr_count <= writes_now;
			end
		end
	end

endmodule

/* exec_issue.sv */
`timescale 1ns/1ps

module exec_issue import exec_pkg::*; (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input exec_req_t req,
	output logic issue_valid,
	output issue_t issue
);

	logic op_known;
	logic type_known;

	// Only the ten arithmetic codes are executed
	always_comb begin
		case (req.op)
			op_add,
			op_sub,
			op_and,
			op_or,
			op_clr,
			op_eq,
			op_lt,
			op_ltu,
			op_xor,
			op_nop: op_known = 1'b1;
			default: op_known = 1'b0;
		endcase
	end

	assign type_known = (req.op_type == op_type_arith);

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= decode_valid;
		end
	end

	// The payload only moves when a new instruction arrives
	always_ff @(posedge clock) begin
		if (decode_valid) begin
			issue.req <= req;
			issue.illegal <= !(type_known && op_known);
		end
	end

endmodule

/* exec_pkg.sv */
package exec_pkg;

	localparam int word_width = 32;
	localparam int reg_addr_width = 6;

	typedef logic [word_width-1:0] word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// Instruction addresses are halfword aligned, so bit 0 is not stored
	typedef logic [31:1] pc_t;

	localparam pc_t reset_pc = '0;
	localparam pc_t pc_step_compressed = 31'd1; // One halfword
	localparam pc_t pc_step_full = 31'd2;
	localparam word_t sign_mask = {1'b1, {(word_width-1){1'b0}}};

	typedef enum logic [4:0] {
		op_type_arith = 5'd0,
		op_type_branch = 5'd1,
		op_type_ldst = 5'd2,
		op_type_mds = 5'd3,
		op_type_csr = 5'd4,
		op_type_jump = 5'd5
	} op_type_t;

	typedef enum logic [5:0] {
		op_add = 6'd0,
		op_sub = 6'd1,
		op_and = 6'd2,
		op_or = 6'd3,
		op_clr = 6'd4,
		op_eq = 6'd5,
		op_lt = 6'd6,
		op_ltu = 6'd7,
		op_xor = 6'd8,
		op_nop = 6'd9
	} alu_op_t;

	typedef struct packed {
		op_type_t op_type;
		alu_op_t op;
		word_t op_a;
		word_t op_b;
		reg_addr_t rd;
		logic instr_c; // Compressed instruction
	} exec_req_t;

	typedef struct packed {
		exec_req_t req;
		logic illegal;
	} issue_t;

	typedef struct packed {
		issue_t issue;
		word_t result;
	} alu_result_t;

	typedef struct packed {
		logic write_count_error;
		logic rd_mismatch;
		logic data_mismatch;
		logic illegal_op;
	} check_status_t;

endpackage

/* exec_unit.f */
exec_pkg.sv
exec_issue.sv
exec_alu.sv
exec_writeback.sv
exec_arith_checker.sv
exec_unit.sv
exec_unit_tb.sv

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input exec_req_t req,
	output logic rd_wen,
	output reg_addr_t rd_waddr,
	output word_t rd_wdata,
	output logic instr_complete,
	output pc_t pc,
	output check_status_t status
);

	logic issue_valid;
	issue_t issue;
	logic alu_valid;
	alu_result_t alu;

	exec_issue issue0 (
		.clock (clock),
		.reset (reset),
		.decode_valid (decode_valid),
		.req (req),
		.issue_valid (issue_valid),
		.issue (issue)
	);

	exec_alu alu0 (
		.clock (clock),
		.reset (reset),
		.issue_valid (issue_valid),
		.issue (issue),
		.alu_valid (alu_valid),
		.alu (alu)
	);

	exec_writeback writeback0 (
		.clock (clock),
		.reset (reset),
		.alu_valid (alu_valid),
		.alu (alu),
		.rd_wen (rd_wen),
		.rd_waddr (rd_waddr),
		.rd_wdata (rd_wdata),
		.instr_complete (instr_complete),
		.pc (pc)
	);

	// Watches the same write port the register file sees
	exec_arith_checker checker0 (
		.clock (clock),
		.reset (reset),
		.issue_valid (issue_valid),
		.issue (issue),
		.rd_wen (rd_wen),
		.rd_waddr (rd_waddr),
		.rd_wdata (rd_wdata),
		.instr_complete (instr_complete),
		.status (status)
	);

endmodule

/* exec_unit_cases.txt */
# Columns in hex: op_type op op_a op_b rd instr_c
# op_type 00 is arithmetic, op 00..09 is add sub and or clr eq lt ltu xor nop
00 00 00000005 00000007 01 0
00 00 ffffffff 00000001 02 0
00 00 7fffffff 00000001 03 1
00 01 00000003 00000005 04 0
00 01 80000000 00000001 05 1
00 02 f0f0f0f0 ff00ff00 06 0
00 03 0f0f0f0f f0000000 07 0
00 04 ffffffff ffffffff 08 0
00 04 12345678 0000ffff 09 1
00 04 ffffffff 00000000 0a 0
00 05 deadbeef deadbeef 0b 0
00 05 deadbeef deadbeee 0c 1
# Signed against unsigned compare
00 06 ffffffff 00000001 0d 0
00 07 ffffffff 00000001 0e 0
00 06 00000001 ffffffff 0f 0
00 07 00000001 ffffffff 10 0
00 06 80000000 7fffffff 11 1
00 07 80000000 7fffffff 12 0
00 06 00000005 00000005 13 0
00 08 aaaaaaaa 55555555 14 0
00 08 12345678 12345678 15 1
00 09 cafef00d 11111111 16 0
# Illegal op_type or op
01 00 00000001 00000001 17 0
00 0a 00000001 00000002 18 0
00 00 00000010 00000020 19 1
1f 3f ffffffff ffffffff 1a 1
00 3f 00000000 00000000 1b 0
00 00 00000000 00000000 00 0
00 02 ffffffff ffffffff 3f 0
00 01 00000000 ffffffff 20 0
00 07 00000000 00000000 21 0
00 05 00000000 00000000 22 1

/* exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*; ();

	localparam int clock_period = 4;
	localparam int reset_cycles = 8;
	localparam int random_count = 200;

	typedef struct packed {
		logic legal;
		reg_addr_t rd;
		word_t data;
		logic instr_c;
		logic [31:0] due; // Cycle in which instr_complete has to show up
	} expect_t;

	logic clock;
	logic reset;
	logic decode_valid;
	exec_req_t req;
	logic rd_wen;
	reg_addr_t rd_waddr;
	word_t rd_wdata;
	logic instr_complete;
	pc_t pc;
	check_status_t status;

	exec_req_t cases[$];
	expect_t pending[$];
	pc_t model_pc;
	check_status_t model_status;
	int unsigned cycle = 0;
	integer seed = 97863;
	logic cases_loaded = 1'b0;

	exec_unit dut0 (.*);

	initial clock = 1'b0;
	always #(clock_period / 2) clock = ~clock;

	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic is_illegal(input exec_req_t r);
		return r.op_type != op_type_arith || r.op > op_nop;
	endfunction

	function automatic word_t expected_result(input exec_req_t r);
		word_t a;
		word_t b;
		a = r.op_a;
		b = r.op_b;
		case (r.op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_clr: return a & ~b;
			op_eq: return (a == b) ? 32'd1 : 32'd0;
			op_lt: begin
				// With different signs the negative operand is the smaller one
				if (a[31] != b[31])
					return a[31] ? 32'd1 : 32'd0;
				return (a < b) ? 32'd1 : 32'd0;
			end
			op_ltu: return (a < b) ? 32'd1 : 32'd0;
			op_xor: return a ^ b;
			op_nop: return a;
			default: return '0;
		endcase
	endfunction

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t actual,
			input reg_addr_t expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_status(input string name, input check_status_t actual,
			input check_status_t expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			stop_run();
		end
	endtask

	// Called once per cycle at the falling edge, where all outputs are settled
	task automatic observe_cycle();
		expect_t e;
		check_status("status", status, model_status);
		if (instr_complete !== 1'b1) begin
			check_bit("rd_wen", rd_wen, 1'b0);
			check_pc("pc", pc, model_pc);
		end else if (pending.size() == 0) begin
			$display("Completion at %0t ns with no instruction in flight", $time);
			stop_run();
		end else begin
			e = pending.pop_front();
			if (e.due != cycle) begin
				$display("Fail at %0t ns: instr_complete cycle is %0d, expected %0d",
					$time, cycle, e.due);
				stop_run();
			end
			model_pc = model_pc + (e.instr_c ? 31'd1 : 31'd2); // Counted in halfwords
			check_pc("pc", pc, model_pc);
			check_bit("rd_wen", rd_wen, e.legal);
			if (e.legal) begin
				check_addr("rd_waddr", rd_waddr, e.rd);
				check_word("rd_wdata", rd_wdata, e.data);
			end else begin
				model_status.illegal_op = 1'b1; // Visible from the next cycle on
			end
		end
		if (pending.size() != 0 && pending[0].due < cycle) begin
			$display("An instruction due in cycle %0d never completed", pending[0].due);
			stop_run();
		end
	endtask

	task automatic issue_instr(input exec_req_t r);
		expect_t e;
		@(negedge clock);
		observe_cycle();
		req = r;
		decode_valid = 1'b1;
		e.legal = !is_illegal(r);
		e.rd = r.rd;
		e.data = expected_result(r);
		e.instr_c = r.instr_c;
		e.due = cycle + 3;
		pending.push_back(e);
	endtask

	task automatic idle_cycle();
		@(negedge clock);
		observe_cycle();
		decode_valid = 1'b0;
	endtask

	task automatic drain_pipeline();
		while (pending.size() != 0)
			idle_cycle();
		idle_cycle(); // Status follows the last completion by one cycle
	endtask

	task automatic issue_random();
		exec_req_t r;
		r.op_type = op_type_arith;
		r.op = alu_op_t'(6'($unsigned($random(seed)) % 10));
		r.op_a = $random(seed);
		r.op_b = $random(seed);
		if ($random(seed) % 4 == 0)
			r.op_b = r.op_a; // Equal operands for eq, lt and ltu
		r.rd = 6'($random(seed));
		r.instr_c = 1'($random(seed));
		issue_instr(r);
	endtask

	task automatic load_cases();
		int fd;
		int n;
		string line;
		logic [31:0] type_field;
		logic [31:0] op_field;
		logic [31:0] a_field;
		logic [31:0] b_field;
		logic [31:0] rd_field;
		logic [31:0] c_field;
		exec_req_t r;
		fd = $fopen("exec_unit_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open exec_unit_cases.txt for reading");
			stop_run();
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h", type_field, op_field, a_field, b_field,
				rd_field, c_field);
			if (n == 6) begin
				r = {type_field[4:0], op_field[5:0], a_field, b_field, rd_field[5:0], c_field[0]};
				cases.push_back(r);
			end
		end
		$fclose(fd);
		if (cases.size() == 0) begin
			$display("The cases file holds no instructions");
			stop_run();
		end
		cases_loaded = 1'b1;
	endtask

	initial begin
		reset = 1'b1;
		decode_valid = 1'b0;
		req = '0;
		model_pc = reset_pc;
		model_status = '0;
		load_cases();
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		foreach (cases[i])
			issue_instr(cases[i]);
		drain_pipeline();
		@(negedge clock);
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		check_pc("pc", pc, reset_pc);
		check_status("status", status, '0);
		model_pc = reset_pc;
		model_status = '0;
		repeat (random_count)
			issue_random();
		drain_pipeline();
		$display("test passed");
		$finish;
	end

	initial begin
		int limit;
		wait (cases_loaded);
		limit = (cases.size() + random_count + 20 + reset_cycles) * clock_period;
		#(limit);
		$display("Timeout after %0d ns, the instructions did not all complete", limit);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* exec_writeback.sv */
`timescale 1ns/1ps

module exec_writeback import exec_pkg::*; (
	input logic clock,
	input logic reset,
	input logic alu_valid,
	input alu_result_t alu,
	output logic rd_wen,
	output reg_addr_t rd_waddr,
	output word_t rd_wdata,
	output logic instr_complete,
	output pc_t pc
);

	logic legal;
	pc_t pc_step;

	assign legal = !alu.issue.illegal;

	assign pc_step = alu.issue.req.instr_c ? pc_step_compressed : pc_step_full;

	// Every instruction completes, but only a legal one writes
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_wen <= 1'b0;
			instr_complete <= 1'b0;
		end else begin
			rd_wen <= alu_valid && legal;
			instr_complete <= alu_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (alu_valid && legal) begin
			rd_waddr <= alu.issue.req.rd;
			rd_wdata <= alu.result;
		end
	end

	// The counter is 31 bits wide and wraps on its own
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (alu_valid) begin
			pc <= pc + pc_step;
		end
	end

endmodule
